// ==== hw/pong_pkg.sv ====
`default_nettype none

package pong_pkg;

	// ************************************************************
	// Field geometry, all in pixels
	localparam int FIELD_W     = 640;
	localparam int FIELD_H     = 480;
	localparam int BALL_SIZE   = 16;
	localparam int PADDLE_LEN  = 80;
	localparam int LEFT_FACE   = 36;
	localparam int RIGHT_FACE  = 604;
	localparam int WALL_BOT    = 464;	// Lowest top edge of the ball
	localparam int MISS_RIGHT  = 624;
	localparam int PADDLE_MAX  = 400;

	localparam int BALL_HOME_X = 312;
	localparam int BALL_HOME_Y = 232;
	localparam int PADDLE_HOME = 200;

	localparam int WIN_SCORE   = 10;
	localparam int SPEED_MAX   = 15;

	// ************************************************************
	// Tick periods in clocks at 50 MHz, one per mode and tick kind
	localparam int BALL_PERIOD_AI_HARD      = 450000;
	localparam int BALL_PERIOD_AI_NORMAL    = 450000;
	localparam int BALL_PERIOD_VERSUS_FAST  = 450000;
	localparam int BALL_PERIOD_VERSUS_CASUAL = 300000;
	localparam int LEFT_PERIOD_AI_HARD      = 60000;
	localparam int LEFT_PERIOD_AI_NORMAL    = 100000;
	localparam int LEFT_PERIOD_VERSUS_FAST  = 100000;
	localparam int LEFT_PERIOD_VERSUS_CASUAL = 200000;
	localparam int AI_PERIOD_AI_HARD        = 40000;
	localparam int AI_PERIOD_AI_NORMAL      = 100000;

	// ************************************************************
	// Character LCD
	localparam int LCD_EN_CYCLES  = 16;
	localparam int LCD_GAP_CYCLES = 262142;
	localparam int LCD_SEQ_LEN    = 38;

	localparam logic [7:0] LCD_CMD_FUNC_SET = 8'h38;	// 8 bit, 2 lines
	localparam logic [7:0] LCD_CMD_DISP_ON  = 8'h0C;
	localparam logic [7:0] LCD_CMD_CLEAR    = 8'h01;
	localparam logic [7:0] LCD_CMD_ENTRY    = 8'h06;
	localparam logic [7:0] LCD_CMD_LINE1    = 8'h80;
	localparam logic [7:0] LCD_CMD_LINE2    = 8'hC0;

	localparam logic [127:0] LCD_TEXT_LINE1 = "Player 1:       ";
	localparam logic [127:0] LCD_TEXT_LINE2 = "Player 2:       ";
	localparam logic [127:0] LCD_TEXT_WIN   = "Player 1 Wins   ";
	localparam logic [127:0] LCD_TEXT_BLANK = {16{8'h20}};
	localparam int LCD_SCORE_COL  = 10;	// Digit after "Player N: "
	localparam int LCD_WINNER_COL = 7;

	typedef logic [9:0] coord_t;
	typedef logic [3:0] score_t;

	typedef enum logic [1:0] {ai_hard, ai_normal, versus_fast, versus_casual} mode_t;

	typedef struct packed {
		mode_t mode;
		logic  active;
		logic  restart;
		logic  up_left;
		logic  down_left;
		logic  up_right;
		logic  down_right;
	} ctrl_s;

	typedef struct packed {
		logic ball_tick;
		logic left_tick;
		logic ai_tick;
	} tick_s;

	typedef struct packed {
		coord_t     ball_x;
		coord_t     ball_y;
		logic       dir_x;	// 1 moves left
		logic       dir_y;	// 1 moves up
		logic [3:0] speed;
		coord_t     left_pos;
		coord_t     right_pos;
		score_t     score_l;
		score_t     score_r;
		logic       over;
	} game_state_s;

endpackage

`default_nettype wire

// ==== hw/input_conditioner.sv ====
`timescale 1ns/100ps
`default_nettype none

module input_conditioner #(
	parameter int tick_div = 1
) (
	input  wire             CLOCK_50,
	input  wire             iRST_N,
	input  wire [3:0]       key_n,
	input  wire [3:0]       mode_sw,
	input  wire             restart_sw,
	output pong_pkg::ctrl_s ctrl,
	output pong_pkg::tick_s ticks
);
	import pong_pkg::*;

	logic [8:0]       sync_1, sync_2;	// {key_n, mode_sw, restart_sw}
	logic [3:0]       key_s, sw_s;
	logic             restart_s;
	mode_t            mode_q;
	logic             mode_chg;
	logic [2:0][19:0] period;	// 2 ball, 1 left, 0 machine player
	logic [2:0]       hit;

	always_ff @(posedge CLOCK_50 or negedge iRST_N) begin
		if (!iRST_N) begin
			sync_1 <= 9'b1111_0000_0;	// Keys released
			sync_2 <= 9'b1111_0000_0;
		end else begin
			sync_1 <= {key_n, mode_sw, restart_sw};
			sync_2 <= sync_1;
		end
	end

	assign {key_s, sw_s, restart_s} = sync_2;

	// Highest switch wins
	always_comb begin
		ctrl.active     = |sw_s;
		ctrl.restart    = restart_s;
		ctrl.up_left    = ~key_s[3];
		ctrl.down_left  = ~key_s[2];
		ctrl.up_right   = ~key_s[0];
		ctrl.down_right = ~key_s[1];
		if (sw_s[3])
			ctrl.mode = ai_hard;
		else if (sw_s[2])
			ctrl.mode = ai_normal;
		else if (sw_s[1])
			ctrl.mode = versus_fast;
		else
			ctrl.mode = versus_casual;
	end

	always_ff @(posedge CLOCK_50 or negedge iRST_N) begin
		if (!iRST_N)
			mode_q <= versus_casual;
		else
			mode_q <= ctrl.mode;
	end

	assign mode_chg = (ctrl.mode != mode_q);

	always_comb begin
		case (ctrl.mode)
			ai_hard: begin
				period[2] = 20'(BALL_PERIOD_AI_HARD / tick_div);
				period[1] = 20'(LEFT_PERIOD_AI_HARD / tick_div);
				period[0] = 20'(AI_PERIOD_AI_HARD / tick_div);
			end
			ai_normal: begin
				period[2] = 20'(BALL_PERIOD_AI_NORMAL / tick_div);
				period[1] = 20'(LEFT_PERIOD_AI_NORMAL / tick_div);
				period[0] = 20'(AI_PERIOD_AI_NORMAL / tick_div);
			end
			versus_fast: begin
				period[2] = 20'(BALL_PERIOD_VERSUS_FAST / tick_div);
				period[1] = 20'(LEFT_PERIOD_VERSUS_FAST / tick_div);
				period[0] = '0;	// No machine player
			end
			default: begin
				period[2] = 20'(BALL_PERIOD_VERSUS_CASUAL / tick_div);
				period[1] = 20'(LEFT_PERIOD_VERSUS_CASUAL / tick_div);
				period[0] = '0;
			end
		endcase
	end

	// ************************************************************
	// Period counters restart on a mode change
	for (genvar k = 0; k < 3; k++) begin : g_tick
		logic [19:0] cnt;

		assign hit[k] = ctrl.active && !mode_chg && (period[k] != '0) &&
			(cnt == period[k] - 20'd1);

		always_ff @(posedge CLOCK_50 or negedge iRST_N) begin
			if (!iRST_N)
				cnt <= '0;
			else if (!ctrl.active || mode_chg || hit[k])
				cnt <= '0;
			else if (period[k] != '0)
				cnt <= cnt + 20'd1;
		end
	end

	assign ticks = '{ball_tick: hit[2], left_tick: hit[1], ai_tick: hit[0]};

	// Switches off at the pins keep the ball still once through the synchronizer
	assert property (@(posedge CLOCK_50) disable iff (!iRST_N)
		(mode_sw == '0) |-> ##2 !ticks.ball_tick);

endmodule

`default_nettype wire

// ==== hw/paddle_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module paddle_control (
	input  wire                   CLOCK_50,
	input  wire                   iRST_N,
	input  wire pong_pkg::ctrl_s  ctrl,
	input  wire pong_pkg::tick_s  ticks,
	input  wire pong_pkg::coord_t ball_y,
	input  wire                   point,
	input  wire                   over,
	output pong_pkg::coord_t      left_pos,
	output pong_pkg::coord_t      right_pos
);
	import pong_pkg::*;

	logic versus;

	// Down first, then up, both inside the limits
	function automatic coord_t step_human(coord_t pos, logic up, logic down);
		coord_t p;
		p = pos;
		if (down && p < coord_t'(PADDLE_MAX))
			p = p + 10'd1;
		if (up && p > '0)
			p = p - 10'd1;
		return p;
	endfunction

	// Machine player chases the ball center
	function automatic coord_t step_ai(coord_t pos, coord_t ball);
		logic [10:0] pad_c, ball_c;
		pad_c  = {1'b0, pos} + 11'(PADDLE_LEN / 2);
		ball_c = {1'b0, ball} + 11'(BALL_SIZE / 2);
		if (pad_c < ball_c && pos < coord_t'(PADDLE_MAX))
			return pos + 10'd1;
		else if (pad_c > ball_c && pos > '0)
			return pos - 10'd1;
		return pos;
	endfunction

	assign versus = (ctrl.mode == versus_fast) || (ctrl.mode == versus_casual);

	always_ff @(posedge CLOCK_50 or negedge iRST_N) begin
		if (!iRST_N) begin
			left_pos  <= coord_t'(PADDLE_HOME);
			right_pos <= coord_t'(PADDLE_HOME);
		end else if (over || point) begin
			left_pos  <= coord_t'(PADDLE_HOME);
			right_pos <= coord_t'(PADDLE_HOME);
		end else begin
			if (ticks.left_tick)
				left_pos <= step_human(left_pos, ctrl.up_left, ctrl.down_left);
			if (versus) begin
				if (ticks.left_tick)	// Second player shares the left rate
					right_pos <= step_human(right_pos, ctrl.up_right, ctrl.down_right);
			end else if (ticks.ai_tick) begin
				right_pos <= step_ai(right_pos, ball_y);
			end
		end
	end

	assert property (@(posedge CLOCK_50) disable iff (!iRST_N)
		(left_pos <= coord_t'(PADDLE_MAX)) && (right_pos <= coord_t'(PADDLE_MAX)));

endmodule

`default_nettype wire

// ==== hw/ball_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module ball_engine (
	input  wire                   CLOCK_50,
	input  wire                   iRST_N,
	input  wire pong_pkg::ctrl_s  ctrl,
	input  wire pong_pkg::tick_s  ticks,
	input  wire pong_pkg::coord_t left_pos,
	input  wire pong_pkg::coord_t right_pos,
	output pong_pkg::game_state_s state,
	output logic                  point
);
	import pong_pkg::*;

	coord_t     ball_x, ball_y;
	logic       dir_x, dir_y;
	logic [3:0] speed;
	score_t     score_l, score_r;
	logic       over;

	coord_t     nx, ny;
	logic       wall, hit_l, hit_r, speed_up;
	logic       miss_l, miss_r, game_won;

	// ************************************************************
	// Next position and collision checks
	always_comb begin
		if (dir_x)
			nx = (ball_x > coord_t'(speed)) ? ball_x - coord_t'(speed) : '0;	// Clamp at 0
		else
			nx = ball_x + coord_t'(speed);
		if (dir_y)
			ny = (ball_y > coord_t'(speed)) ? ball_y - coord_t'(speed) : '0;
		else
			ny = ball_y + coord_t'(speed);

		wall  = (ny == '0) || (ny >= coord_t'(WALL_BOT));
		hit_l = dir_x && (nx <= coord_t'(LEFT_FACE)) &&
			(ny < left_pos + PADDLE_LEN) && (ny + BALL_SIZE > left_pos);
		hit_r = !dir_x && (nx + BALL_SIZE >= RIGHT_FACE) &&
			(ny < right_pos + PADDLE_LEN) && (ny + BALL_SIZE > right_pos);
		speed_up = (ctrl.mode != versus_casual) && (speed < 4'(SPEED_MAX));

		miss_l = (nx == '0);	// Point for the right player
		miss_r = !miss_l && (nx >= coord_t'(MISS_RIGHT));
		if (miss_l)
			game_won = (score_r == score_t'(WIN_SCORE - 1));
		else
			game_won = (score_l == score_t'(WIN_SCORE - 1));
	end

	always_ff @(posedge CLOCK_50 or negedge iRST_N) begin
		if (!iRST_N) begin
			ball_x  <= coord_t'(BALL_HOME_X);
			ball_y  <= coord_t'(BALL_HOME_Y);
			dir_x   <= 1'b0;
			dir_y   <= 1'b0;
			speed   <= 4'd1;
			score_l <= '0;
			score_r <= '0;
			over    <= 1'b0;
			point   <= 1'b0;
		end else begin
			point <= 1'b0;
			if (over) begin
				// Frozen at home until restart
				if (ctrl.restart) begin
					score_l <= '0;
					score_r <= '0;
					speed   <= 4'd1;
					over    <= 1'b0;
				end
			end else if (ticks.ball_tick) begin
				if (miss_l || miss_r) begin
					ball_x <= coord_t'(BALL_HOME_X);
					ball_y <= coord_t'(BALL_HOME_Y);
					dir_x  <= 1'b0;
					dir_y  <= 1'b0;
					point  <= 1'b1;
					if (miss_l)
						score_r <= score_r + 4'd1;
					else
						score_l <= score_l + 4'd1;
					speed <= game_won ? 4'd0 : 4'd1;
					over  <= game_won;
				end else begin
					ball_x <= nx;
					ball_y <= ny;
					dir_y  <= dir_y ^ wall;
					dir_x  <= dir_x ^ (hit_l | hit_r);
					if ((hit_l || hit_r) && speed_up)
						speed <= speed + 4'd1;
				end
			end
		end
	end

	assign state = '{
		ball_x: ball_x, ball_y: ball_y, dir_x: dir_x, dir_y: dir_y, speed: speed,
		left_pos: left_pos, right_pos: right_pos,
		score_l: score_l, score_r: score_r, over: over
	};

	// Speed saturates, and only a point takes it off the ceiling
	assert property (@(posedge CLOCK_50) disable iff (!iRST_N)
		(speed == 4'(SPEED_MAX)) |=> (speed == 4'(SPEED_MAX)) || point);

	assert property (@(posedge CLOCK_50) disable iff (!iRST_N)
		(score_l <= score_t'(WIN_SCORE)) && (score_r <= score_t'(WIN_SCORE)));

endmodule

`default_nettype wire

// ==== hw/lcd_score_text.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_score_text #(
	parameter int tick_div = 1
) (
	input  wire                   CLOCK_50,
	input  wire                   iRST_N,
	input  wire pong_pkg::score_t score_l,
	input  wire pong_pkg::score_t score_r,
	input  wire                   over,
	input  wire                   done,
	output logic                  start,
	output logic [7:0]            data,
	output logic                  rs
);
	import pong_pkg::*;

	typedef enum logic [1:0] {st_send, st_wait, st_gap, st_idle} seq_state_t;

	seq_state_t  state;
	logic [5:0]  idx;
	logic [17:0] gap_cnt;
	score_t      cap_l, cap_r;	// Values shown by the current pass
	logic        cap_over;
	logic        stale;
	logic [8:0]  entry;	// {rs, byte}

	// ************************************************************
	// Write sequence: 5 init commands, line 1, C0, line 2
	function automatic logic [8:0] seq_entry(logic [5:0] i, score_t sl, score_t sr,
			logic ov);
		logic         line2;
		logic [3:0]   col;
		logic [127:0] txt;
		logic [7:0]   ch;
		case (i)
			6'd0:  return {1'b0, LCD_CMD_FUNC_SET};
			6'd1:  return {1'b0, LCD_CMD_DISP_ON};
			6'd2:  return {1'b0, LCD_CMD_CLEAR};
			6'd3:  return {1'b0, LCD_CMD_ENTRY};
			6'd4:  return {1'b0, LCD_CMD_LINE1};
			6'd21: return {1'b0, LCD_CMD_LINE2};
			default: ;
		endcase
		line2 = (i > 6'd21);
		col   = line2 ? 4'(i - 6'd22) : 4'(i - 6'd5);
		if (line2)
			txt = ov ? LCD_TEXT_BLANK : LCD_TEXT_LINE2;
		else
			txt = ov ? LCD_TEXT_WIN : LCD_TEXT_LINE1;
		ch = txt[8 * (15 - col) +: 8];
		if (!ov && col == 4'(LCD_SCORE_COL))
			ch = 8'h30 + {4'b0, (line2 ? sr : sl)};	// ASCII digit
		if (ov && !line2 && col == 4'(LCD_WINNER_COL))
			ch = (sl == score_t'(WIN_SCORE)) ? 8'h31 : 8'h32;
		return {1'b1, ch};
	endfunction

	assign entry = seq_entry(idx, cap_l, cap_r, cap_over);
	assign stale = (score_l != cap_l) || (score_r != cap_r) || (over != cap_over);

	always_ff @(posedge CLOCK_50 or negedge iRST_N) begin
		if (!iRST_N) begin
			state    <= st_send;
			idx      <= '0;
			gap_cnt  <= '0;
			cap_l    <= '0;
			cap_r    <= '0;
			cap_over <= 1'b0;
			start    <= 1'b0;
			data     <= '0;
			rs       <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				st_send: begin
					start <= 1'b1;
					data  <= entry[7:0];
					rs    <= entry[8];
					state <= st_wait;
				end
				st_wait: if (done) begin
					gap_cnt <= '0;
					state   <= st_gap;
				end
				st_gap: begin
					if (gap_cnt >= 18'(LCD_GAP_CYCLES / tick_div - 1)) begin
						if (idx == 6'(LCD_SEQ_LEN - 1)) begin
							state <= st_idle;
						end else begin
							idx   <= idx + 6'd1;
							state <= st_send;
						end
					end else begin
						gap_cnt <= gap_cnt + 18'd1;
					end
				end
				default: if (stale) begin	// New pass with fresh values
					idx      <= '0;
					cap_l    <= score_l;
					cap_r    <= score_r;
					cap_over <= over;
					state    <= st_send;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/lcd_bus_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_driver (
	input  wire        CLOCK_50,
	input  wire        iRST_N,
	input  wire        start,
	input  wire [7:0]  data,
	input  wire        rs,
	output logic       done,
	output logic [7:0] lcd_data,
	output logic       lcd_en,
	output logic       lcd_rs
);
	import pong_pkg::*;

	typedef enum logic [1:0] {bus_idle, bus_pulse, bus_tail} bus_state_t;

	bus_state_t state;
	logic [4:0] en_cnt;

	always_ff @(posedge CLOCK_50 or negedge iRST_N) begin
		if (!iRST_N) begin
			state    <= bus_idle;
			en_cnt   <= '0;
			done     <= 1'b0;
			lcd_en   <= 1'b0;
			lcd_data <= '0;
			lcd_rs   <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				bus_idle: if (start) begin
					lcd_data <= data;	// Held until the next write
					lcd_rs   <= rs;
					lcd_en   <= 1'b1;
					en_cnt   <= '0;
					state    <= bus_pulse;
				end
				bus_pulse: begin
					if (en_cnt == 5'(LCD_EN_CYCLES - 1)) begin
						lcd_en <= 1'b0;
						state  <= bus_tail;
					end else begin
						en_cnt <= en_cnt + 5'd1;
					end
				end
				default: begin
					done  <= 1'b1;	// One cycle after enable falls
					state <= bus_idle;
				end
			endcase
		end
	end

	assert property (@(posedge CLOCK_50) disable iff (!iRST_N)
		($past(lcd_en) && lcd_en) |-> ($stable(lcd_data) && $stable(lcd_rs)));

endmodule

`default_nettype wire

// ==== hw/pong_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pong_top #(
	parameter int tick_div = 1
) (
	input  wire                   CLOCK_50,
	input  wire                   iRST_N,
	input  wire [3:0]             key_n,
	input  wire [3:0]             mode_sw,
	input  wire                   restart_sw,
	output logic [7:0]            lcd_data,
	output logic                  lcd_en,
	output logic                  lcd_rs,
	output pong_pkg::game_state_s game_state
);
	import pong_pkg::*;

	ctrl_s      ctrl;
	tick_s      ticks;
	coord_t     left_pos, right_pos;
	logic       point;
	logic       lcd_start, lcd_done, lcd_cmd_rs;
	logic [7:0] lcd_byte;

	// ************************************************************
	// Game core
	input_conditioner #(.tick_div(tick_div)) input_conditioner_inst (
		.CLOCK_50(CLOCK_50), .iRST_N(iRST_N),
		.key_n(key_n), .mode_sw(mode_sw), .restart_sw(restart_sw),
		.ctrl(ctrl), .ticks(ticks)
	);

	paddle_control paddle_control_inst (
		.CLOCK_50(CLOCK_50), .iRST_N(iRST_N),
		.ctrl(ctrl), .ticks(ticks), .ball_y(game_state.ball_y),
		.point(point), .over(game_state.over),
		.left_pos(left_pos), .right_pos(right_pos)
	);

	ball_engine ball_engine_inst (
		.CLOCK_50(CLOCK_50), .iRST_N(iRST_N),
		.ctrl(ctrl), .ticks(ticks), .left_pos(left_pos), .right_pos(right_pos),
		.state(game_state), .point(point)
	);

	// ************************************************************
	// Score display
	lcd_score_text #(.tick_div(tick_div)) lcd_score_text_inst (
		.CLOCK_50(CLOCK_50), .iRST_N(iRST_N),
		.score_l(game_state.score_l), .score_r(game_state.score_r),
		.over(game_state.over), .done(lcd_done),
		.start(lcd_start), .data(lcd_byte), .rs(lcd_cmd_rs)
	);

	lcd_bus_driver lcd_bus_driver_inst (
		.CLOCK_50(CLOCK_50), .iRST_N(iRST_N),
		.start(lcd_start), .data(lcd_byte), .rs(lcd_cmd_rs),
		.done(lcd_done), .lcd_data(lcd_data), .lcd_en(lcd_en), .lcd_rs(lcd_rs)
	);

endmodule

`default_nettype wire

// ==== verification/pong_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pong_tb;
	import pong_pkg::*;

	logic        CLOCK_50;
	logic        iRST_N;
	logic [3:0]  key_n;
	logic [3:0]  mode_sw;
	logic        restart_sw;
	wire  [7:0]  lcd_data;
	wire         lcd_en;
	wire         lcd_rs;
	game_state_s game_state;

	int          errors = 0;
	int          timeouts = 0;
	logic [31:0] rng = 32'd11471;
	logic [7:0]  scr [32];	// 2x16 screen model
	int          cursor;

	game_state_s prev;	// Last observed state and the inputs that act on it
	tick_s       ptk;
	ctrl_s       pc;
	logic        ppt;
	logic        have_prev;
	logic        chk_en;

	pong_top #(.tick_div(1000)) pong_top_inst (
		.CLOCK_50(CLOCK_50), .iRST_N(iRST_N),
		.key_n(key_n), .mode_sw(mode_sw), .restart_sw(restart_sw),
		.lcd_data(lcd_data), .lcd_en(lcd_en), .lcd_rs(lcd_rs),
		.game_state(game_state)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #4 CLOCK_50 = ~CLOCK_50;
	end

	// ************************************************************
	// Helpers
	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(string name, logic [127:0] exp, logic [127:0] act);
		if (exp !== act) begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
			errors++;
		end
	endtask

	function automatic logic [127:0] text(string s);
		logic [127:0] t;
		t = {16{8'h20}};	// Space padded
		for (int i = 0; i < s.len() && i < 16; i++)
			t[8 * (15 - i) +: 8] = s[i];
		return t;
	endfunction

	function automatic logic [127:0] screen_line(int row);
		logic [127:0] t;
		for (int i = 0; i < 16; i++)
			t[8 * (15 - i) +: 8] = scr[row * 16 + i];
		return t;
	endfunction

	// ************************************************************
	// Reference model of one clock of the game
	function automatic coord_t step_paddle(int pos, logic up, logic down);
		int p;
		p = pos;
		if (down && p < PADDLE_MAX)
			p = p + 1;
		if (up && p > 0)
			p = p - 1;
		return coord_t'(p);
	endfunction

	function automatic coord_t chase(int pos, int by);
		int pcen, bcen;
		pcen = pos + PADDLE_LEN / 2;
		bcen = by + BALL_SIZE / 2;
		if (pcen < bcen && pos < PADDLE_MAX)
			return coord_t'(pos + 1);
		if (pcen > bcen && pos > 0)
			return coord_t'(pos - 1);
		return coord_t'(pos);
	endfunction

	function automatic game_state_s next_state(game_state_s s, tick_s tk, ctrl_s c, logic pt);
		game_state_s n;
		int          bx, by, lp, rp, sp, nx, ny;
		logic        hit;
		n  = s;
		bx = s.ball_x;
		by = s.ball_y;
		lp = s.left_pos;
		rp = s.right_pos;
		sp = s.speed;
		if (s.over) begin
			if (c.restart) begin
				n.score_l = '0;
				n.score_r = '0;
				n.speed   = 4'd1;
				n.over    = 1'b0;
			end
		end else if (tk.ball_tick) begin
			nx = s.dir_x ? bx - sp : bx + sp;
			ny = s.dir_y ? by - sp : by + sp;
			if (nx < 0)
				nx = 0;
			if (ny < 0)
				ny = 0;
			if (ny == 0 || ny >= WALL_BOT)
				n.dir_y = ~s.dir_y;
			hit = (s.dir_x && nx <= LEFT_FACE && ny < lp + PADDLE_LEN && ny + BALL_SIZE > lp) ||
				(!s.dir_x && nx + BALL_SIZE >= RIGHT_FACE && ny < rp + PADDLE_LEN &&
				ny + BALL_SIZE > rp);
			if (hit) begin
				n.dir_x = ~s.dir_x;
				if (c.mode != versus_casual && sp < SPEED_MAX)
					n.speed = 4'(sp + 1);
			end
			n.ball_x = coord_t'(nx);
			n.ball_y = coord_t'(ny);
			if (nx == 0 || nx >= MISS_RIGHT) begin
				if (nx == 0)
					n.score_r = s.score_r + 4'd1;
				else
					n.score_l = s.score_l + 4'd1;
				n.ball_x = coord_t'(BALL_HOME_X);
				n.ball_y = coord_t'(BALL_HOME_Y);
				n.dir_x  = 1'b0;
				n.dir_y  = 1'b0;
				n.speed  = 4'd1;
				if (n.score_l == WIN_SCORE || n.score_r == WIN_SCORE) begin
					n.over  = 1'b1;
					n.speed = 4'd0;
				end
			end
		end
		if (s.over || pt) begin
			n.left_pos  = coord_t'(PADDLE_HOME);
			n.right_pos = coord_t'(PADDLE_HOME);
		end else begin
			if (tk.left_tick)
				n.left_pos = step_paddle(lp, c.up_left, c.down_left);
			if (c.mode == versus_fast || c.mode == versus_casual) begin
				if (tk.left_tick)
					n.right_pos = step_paddle(rp, c.up_right, c.down_right);
			end else if (tk.ai_tick) begin
				n.right_pos = chase(rp, by);
			end
		end
		return n;
	endfunction

	// ************************************************************
	// Comparison against the reference once per clock
	always @(negedge CLOCK_50) begin : compare
		game_state_s exp;
		int          pcen, bcen;
		if (!chk_en) begin
			have_prev = 1'b0;
		end else begin
			if (have_prev) begin
				exp = next_state(prev, ptk, pc, ppt);
				if (game_state != prev || exp != prev)
					check("game_state", exp, game_state);
				if ((pc.mode == ai_hard || pc.mode == ai_normal) && ptk.ai_tick &&
						!prev.over && !ppt) begin
					pcen = prev.right_pos + PADDLE_LEN / 2;
					bcen = prev.ball_y + BALL_SIZE / 2;
					if (pcen == bcen)
						check("ai_hold", prev.right_pos, game_state.right_pos);
					else if (game_state.right_pos != prev.right_pos)
						check("ai_toward", bcen > pcen, game_state.right_pos > prev.right_pos);
				end
				ppt = !prev.over && (exp.score_l != prev.score_l || exp.score_r != prev.score_r);
			end else begin
				ppt = 1'b0;
			end
			prev      = game_state;
			ptk       = pong_top_inst.ticks;
			pc        = pong_top_inst.ctrl;
			have_prev = 1'b1;
		end
	end

	// LCD bus monitor decoding one byte per falling enable
	always @(negedge lcd_en) begin
		if (iRST_N) begin
			if (lcd_rs) begin
				if (cursor < 32)
					scr[cursor] = lcd_data;
				cursor++;
			end else if (lcd_data == 8'h80) begin
				cursor = 0;
			end else if (lcd_data == 8'hC0) begin
				cursor = 16;
			end else if (lcd_data == 8'h01) begin
				foreach (scr[i])
					scr[i] = 8'h20;
				cursor = 0;
			end
		end
	end

	task automatic wait_screen(string name, string l1, string l2);
		int n;
		n = 0;
		while ((screen_line(0) != text(l1) || screen_line(1) != text(l2)) && n < 60000) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (n >= 60000) begin
			$display("Timeout: the LCD never showed the expected text in %s", name);
			timeouts++;
		end
		check({name, "_line1"}, text(l1), screen_line(0));
		check({name, "_line2"}, text(l2), screen_line(1));
	endtask

	task automatic random_buttons(int steps);
		repeat (steps) begin
			rng = xorshift(rng);
			@(posedge CLOCK_50);
			key_n <= rng[3:0];
			repeat (49) @(posedge CLOCK_50);
		end
	endtask

	// ************************************************************
	// Stimulus
	initial begin
		int     n;
		int     rounds;
		score_t last_l, last_r;
		key_n      = 4'hF;
		mode_sw    = 4'h0;
		restart_sw = 1'b0;
		iRST_N     = 1'b0;
		chk_en     = 1'b0;
		have_prev  = 1'b0;
		ppt        = 1'b0;
		cursor     = 0;
		foreach (scr[i])
			scr[i] = 8'h20;
		repeat (16) @(posedge CLOCK_50);
		iRST_N <= 1'b1;
		@(posedge CLOCK_50);
		chk_en = 1'b1;

		@(negedge CLOCK_50);	// Home after reset
		check("reset_ball_x", BALL_HOME_X, game_state.ball_x);
		check("reset_ball_y", BALL_HOME_Y, game_state.ball_y);
		check("reset_left", PADDLE_HOME, game_state.left_pos);
		check("reset_right", PADDLE_HOME, game_state.right_pos);
		check("reset_speed", 1, game_state.speed);
		check("reset_scores", 0, {game_state.score_l, game_state.score_r});
		wait_screen("reset_screen", "Player 1: 0", "Player 2: 0");

		@(posedge CLOCK_50);
		mode_sw <= 4'b0001;	// versus_casual
		random_buttons(4000);

		// Paddles to their limits in versus_fast
		@(posedge CLOCK_50);
		mode_sw <= 4'b0010;
		key_n   <= 4'b1010;	// Left down, right up
		n = 0;
		while (!(game_state.left_pos == PADDLE_MAX && game_state.right_pos == 0) && n < 100000) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (n >= 100000) begin
			$display("Timeout: paddles did not reach the bottom and top limits");
			timeouts++;
		end
		repeat (1000) @(negedge CLOCK_50);
		check("left_at_max", PADDLE_MAX, game_state.left_pos);
		check("right_at_zero", 0, game_state.right_pos);
		@(posedge CLOCK_50);
		key_n <= 4'b0101;	// Left up, right down
		n = 0;
		while (!(game_state.left_pos == 0 && game_state.right_pos == PADDLE_MAX) && n < 100000) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (n >= 100000) begin
			$display("Timeout: paddles did not reach the top and bottom limits");
			timeouts++;
		end
		repeat (1000) @(negedge CLOCK_50);
		check("left_at_zero", 0, game_state.left_pos);
		check("right_at_max", PADDLE_MAX, game_state.right_pos);

		// Machine player in both ai modes
		@(posedge CLOCK_50);
		mode_sw <= 4'b1000;
		random_buttons(3000);
		@(posedge CLOCK_50);
		mode_sw <= 4'b0100;
		random_buttons(3000);

		// ************************************************************
		// Left paddle parked low so that the right player scores
		@(negedge CLOCK_50);
		if (game_state.over) begin
			@(posedge CLOCK_50);
			restart_sw <= 1'b1;
			n = 0;
			while (game_state.over && n < 1000) begin
				@(negedge CLOCK_50);
				n++;
			end
			if (n >= 1000) begin
				$display("Timeout: restart before the scoring test did not clear game over");
				timeouts++;
			end
			@(posedge CLOCK_50);
			restart_sw <= 1'b0;
		end
		@(posedge CLOCK_50);
		mode_sw <= 4'b1000;
		key_n   <= 4'b1011;
		rounds = 0;
		while (!game_state.over && rounds < 30) begin
			last_l = game_state.score_l;
			last_r = game_state.score_r;
			n = 0;
			while (game_state.score_l == last_l && game_state.score_r == last_r && n < 1000000) begin
				@(negedge CLOCK_50);
				n++;
			end
			if (n >= 1000000) begin
				$display("Timeout: no point was scored");
				timeouts++;
				break;
			end
			check("point_ball_x", BALL_HOME_X, game_state.ball_x);
			check("point_ball_y", BALL_HOME_Y, game_state.ball_y);
			if (!game_state.over)
				wait_screen("score_screen", $sformatf("Player 1: %0d", game_state.score_l),
					$sformatf("Player 2: %0d", game_state.score_r));
			rounds++;
		end

		// Game over and restart
		check("over_high", 1, game_state.over);
		check("winner_score", WIN_SCORE, game_state.score_r);
		repeat (3000) @(negedge CLOCK_50);
		check("frozen_ball_x", BALL_HOME_X, game_state.ball_x);
		check("frozen_ball_y", BALL_HOME_Y, game_state.ball_y);
		check("frozen_speed", 0, game_state.speed);
		wait_screen("win_screen", "Player 2 Wins", "");
		@(posedge CLOCK_50);
		restart_sw <= 1'b1;
		n = 0;
		while (game_state.over && n < 1000) begin
			@(negedge CLOCK_50);
			n++;
		end
		if (n >= 1000) begin
			$display("Timeout: restart did not clear the game over state");
			timeouts++;
		end
		@(posedge CLOCK_50);
		restart_sw <= 1'b0;
		check("restart_scores", 0, {game_state.score_l, game_state.score_r});
		wait_screen("restart_screen", "Player 1: 0", "Player 2: 0");

		$display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pong_score.f ====
hw/pong_pkg.sv
hw/input_conditioner.sv
hw/paddle_control.sv
hw/ball_engine.sv
hw/lcd_score_text.sv
hw/lcd_bus_driver.sv
hw/pong_top.sv
verification/pong_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pong score testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f pong_score.f \
	--top-module pong_tb \
	-o pong_sim

./obj_dir/pong_sim | tee sim.log

if grep -q "Test passed" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
